// ==== src.f ====
verilog/board_pkg.sv
verilog/audio_pkg.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/sound_level_meter.sv
verilog/seven_seg_formatter.sv
verilog/tm1638_board_controller.sv
verilog/board_specific_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_board_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sound meter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_board_top -o sim_board
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_board)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

// ==== testbench/tb_board_top.sv ====
// Sound meter board testbench

`timescale 1ns/1ns

module tb_board_top;

    logic        clk;
    logic        rst_n;
    logic        mic_sd;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        tm_clk;
    logic        tm_stb;
    logic        tm_dio_out;
    logic        tm_dio_oe;
    logic        tm_dio_in;
    logic        epoch_start;
    logic        check_req;
    logic [23:0] cur_sample;
    logic [7:0]  key_state;
    logic [31:0] rng;
    int          frame_count;
    int          error_count;
    int          check_count;

    tb_clock_gen i_clock (.clk(clk), .rst_n(rst_n));

    board_specific_top board_specific_top_i
    (
        .CLK        ( clk        ),
        .rst_n      ( rst_n      ),
        .MIC_SD     ( mic_sd     ),
        .MIC_SCK    ( mic_sck    ),
        .MIC_WS     ( mic_ws     ),
        .MIC_LR     ( mic_lr     ),
        .TM_CLK     ( tm_clk     ),
        .TM_STB     ( tm_stb     ),
        .TM_DIO_OUT ( tm_dio_out ),
        .TM_DIO_OE  ( tm_dio_oe  ),
        .TM_DIO_IN  ( tm_dio_in  )
    );

    tb_checker i_checker
    (
        .clk (clk), .rst_n (rst_n),
        .tm_clk (tm_clk), .tm_stb (tm_stb), .tm_dio_out (tm_dio_out), .tm_dio_oe (tm_dio_oe),
        .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_lr (mic_lr),
        .epoch_start (epoch_start), .epoch_sample (cur_sample), .epoch_keys (key_state),
        .check_req (check_req),
        .frame_count (frame_count), .error_count (error_count), .check_count (check_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;

        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    //--------------------------------------------------
    // Microphone and key models

    logic        prev_sck;
    logic        prev_ws;
    logic        prev_oe;
    logic        prev_tclk;
    logic [23:0] mic_word;
    int          slot_bit;
    int          read_bit;

    always @(posedge clk)
    begin
        if (!mic_sck && prev_sck)
        begin
            slot_bit++;
            if (!mic_ws && prev_ws)
            begin
                mic_word = cur_sample;              // Left slot starts
                slot_bit = 0;
            end
        end
        if (!tm_dio_oe && prev_oe)
            read_bit = 0;
        else if (!tm_dio_oe && tm_clk && !prev_tclk)
            read_bit++;
        prev_sck  = mic_sck;
        prev_ws   = mic_ws;
        prev_oe   = tm_dio_oe;
        prev_tclk = tm_clk;
        #5;
        mic_sd    = (slot_bit >= 1 && slot_bit <= 24) ? mic_word[24 - slot_bit] : 1'b0;
        if (read_bit % 8 == 0)
            tm_dio_in = key_state[2 * (read_bit / 8) % 8];
        else if (read_bit % 8 == 4)
            tm_dio_in = key_state[(2 * (read_bit / 8) + 1) % 8];
        else
            tm_dio_in = 1'b0;
    end

    //--------------------------------------------------
    // Epoch sequencing

    task automatic wait_frames(input int n);
        int target;
        int cycles;

        target = frame_count + n;
        cycles = 0;
        while (frame_count < target && cycles < 40000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (frame_count < target)
        begin
            $display("Timed out waiting for panel frames after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic run_epoch(input logic [23:0] sample, input logic [7:0] keys);
        @(posedge clk);
        #5;
        cur_sample  = sample;
        key_state   = keys;
        epoch_start = 1'b1;
        @(posedge clk);
        #5 epoch_start = 1'b0;
        wait_frames(4);                             // Sample, key scan, then clean frames
        #5 check_req = 1'b1;
        @(posedge clk);
        #5 check_req = 1'b0;
    endtask

    initial
    begin
        int cycles;
        int k;

        mic_sd      = 1'b0;
        tm_dio_in   = 1'b0;
        epoch_start = 1'b0;
        check_req   = 1'b0;
        cur_sample  = '0;
        key_state   = '0;
        slot_bit    = 0;
        read_bit    = 0;
        mic_word    = '0;
        rng         = 32'd14;
        cycles      = 0;
        while (!rst_n && cycles < 100)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n)
        begin
            $display("Reset was never released");
            $display("TEST FAILED");
            $finish;
        end

        run_epoch(24'h000000, 8'h00);               // Reset state of the meter
        for (int e = 0; e < 30; e++)
        begin
            rng = xorshift(rng);
            if (rng[1:0] != 2'd3)
            begin
                rng = xorshift(rng);
                run_epoch(24'($signed(rng[23:0]) >>> (rng[27:24] % 12)), key_state);
            end
            else
            begin
                rng = xorshift(rng);
                k   = (rng[1:0] < 2) ? int'(rng[1:0]) : 2 + int'(rng[15:8] % 6);
                run_epoch(cur_sample, 8'(1 << k));  // Press
                run_epoch(cur_sample, 8'h00);       // Release
            end
        end

        @(posedge clk);
        $display("Checks: %0d, frames: %0d, errors: %0d", check_count, frame_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== testbench/tb_checker.sv ====
// Panel frame checker

`timescale 1ns/1ns

module tb_checker
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tm_clk,
    input  logic        tm_stb,
    input  logic        tm_dio_out,
    input  logic        tm_dio_oe,
    input  logic        mic_sck,
    input  logic        mic_ws,
    input  logic        mic_lr,
    input  logic        epoch_start,
    input  logic [23:0] epoch_sample,
    input  logic [7:0]  epoch_keys,
    input  logic        check_req,
    output int          frame_count,
    output int          error_count,
    output int          check_count
);

    logic [7:0]  txn_bytes [0:16];
    logic [7:0]  pend_seg  [0:7];
    logic [7:0]  last_seg  [0:7];
    logic [7:0]  pend_led;
    logic [7:0]  last_led;
    logic [7:0]  cur_byte;
    logic [7:0]  exp_op    [0:3];
    int          exp_len   [0:3];
    int          bit_idx;
    int          nbytes;
    int          seq_pos;
    logic        prev_clk;
    logic        prev_stb;
    logic        reset_checked;
    logic [23:0] peak;
    logic [23:0] latest;
    logic [7:0]  model_keys;
    logic        show_peak;

    initial
    begin
        exp_op[0]  = 8'h40;
        exp_op[1]  = 8'hC0;
        exp_op[2]  = 8'h8F;
        exp_op[3]  = 8'h42;
        exp_len[0] = 1;
        exp_len[1] = 17;
        exp_len[2] = 1;
        exp_len[3] = 5;
    end

    //--------------------------------------------------
    // Reference model helpers

    // Segment a is bit 7 down to g in bit 1, bit 0 is the point
    function automatic logic [7:0] seg_mask(input string lit);
        logic [7:0] m;

        m = '0;
        for (int i = 0; i < lit.len(); i++)
            m[7 - (lit[i] - "a")] = 1'b1;
        return m;
    endfunction

    function automatic logic [7:0] hex_segments(input logic [3:0] n);
        string s;

        case (n)
            4'h0:    s = "abcdef";
            4'h1:    s = "bc";
            4'h2:    s = "abdeg";
            4'h3:    s = "abcdg";
            4'h4:    s = "bcfg";
            4'h5:    s = "acdfg";
            4'h6:    s = "acdefg";
            4'h7:    s = "abc";
            4'h8:    s = "abcdefg";
            4'h9:    s = "abcdfg";
            4'hA:    s = "abcefg";
            4'hB:    s = "cdefg";
            4'hC:    s = "adef";
            4'hD:    s = "bcdeg";
            4'hE:    s = "adefg";
            default: s = "aefg";
        endcase
        return seg_mask(s);
    endfunction

    function automatic logic [23:0] magnitude(input logic [23:0] v);
        return v[23] ? (~v + 24'd1) : v;
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        error_count++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    endtask

    //--------------------------------------------------
    // Transaction decode

    task automatic end_transaction();
        logic [7:0] op;

        op = txn_bytes[0];
        if (nbytes == 0 || op != exp_op[seq_pos])
        begin
            report("framing opcode", 32'(exp_op[seq_pos]), 32'(op));
            seq_pos = (op == 8'h40) ? 1 : 0;        // Resync on the first opcode
        end
        else if (nbytes != exp_len[seq_pos])
        begin
            report("framing byte count", 32'(exp_len[seq_pos]), 32'(nbytes));
            seq_pos = 0;
        end
        else
        begin
            if (seq_pos == 1)
            begin
                for (int i = 0; i < 8; i++)
                begin
                    pend_seg[i] = txn_bytes[1 + 2 * i];
                    pend_led[i] = txn_bytes[2 + 2 * i][0];
                end
            end
            if (seq_pos == 3)
            begin
                last_seg    = pend_seg;             // Whole frame is now valid
                last_led    = pend_led;
                frame_count++;
            end
            seq_pos = (seq_pos + 1) % 4;
        end
    endtask

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prev_clk      = 1'b1;
            prev_stb      = 1'b1;
            bit_idx       = 0;
            nbytes        = 0;
            seq_pos       = 0;
            frame_count   = 0;
            reset_checked = 1'b0;
            peak          = '0;
            latest        = '0;
            model_keys    = '0;
            show_peak     = 1'b0;
        end
        else
        begin
            if (!reset_checked)
            begin
                if (!tm_stb || !tm_clk || !tm_dio_oe || !tm_dio_out || mic_ws || mic_sck)
                begin
                    error_count++;
                    $display("Outputs are not idle right after reset");
                end
                reset_checked = 1'b1;
            end

            if (mic_lr !== 1'b0)
                report("mic channel select", 32'd0, 32'(mic_lr));

            if (!tm_stb && prev_stb)
            begin
                bit_idx = 0;                        // New transaction
                nbytes  = 0;
            end

            if (tm_stb && !tm_dio_oe)
            begin
                error_count++;
                $display("Data line released while no transaction runs");
            end

            if (!tm_stb && tm_clk && !prev_clk)
            begin
                logic exp_oe;

                exp_oe = !(nbytes >= 1 && txn_bytes[0] == 8'h42);   // Panel drives only reads
                if (tm_dio_oe != exp_oe)
                    report("dio output enable", 32'(exp_oe), 32'(tm_dio_oe));
                cur_byte[bit_idx] = tm_dio_out;     // LSB first
                bit_idx++;
                if (bit_idx == 8)
                begin
                    if (nbytes < 17)
                        txn_bytes[nbytes] = cur_byte;
                    nbytes++;
                    bit_idx = 0;
                end
            end

            if (tm_stb && !prev_stb)
                end_transaction();

            prev_clk = tm_clk;
            prev_stb = tm_stb;

            //--------------------------------------------------
            // Model update and comparison

            if (epoch_start)
            begin
                if (epoch_keys[0] && !model_keys[0])
                    peak = '0;
                if (epoch_keys[1] && !model_keys[1])
                    show_peak = !show_peak;
                model_keys = epoch_keys;
                latest     = epoch_sample;
                if (magnitude(latest) > peak)
                    peak = magnitude(latest);
            end

            if (check_req)
            begin
                logic [23:0] value;
                logic [7:0]  exp_led;
                logic [7:0]  exp_seg;

                value = show_peak ? peak : latest;
                for (int i = 0; i < 8; i++)
                    exp_led[i] = peak >= (24'd1 << (16 + i));
                for (int d = 0; d < 8; d++)
                begin
                    exp_seg = (d < 6) ? hex_segments(value[4 * d +: 4]) : 8'h00;
                    if (last_seg[d] != exp_seg)
                        report(show_peak ? "peak digit" : "sample digit",
                               32'(exp_seg), 32'(last_seg[d]));
                end
                if (last_led != exp_led)
                    report("led bar", 32'(exp_led), 32'(last_led));
                check_count++;
            end
        end
    end

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset

`timescale 1ns/1ns

module tb_clock_gen
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #5 rst_n = 1'b1;                // Released like any other input
    end

    always #50 clk = ~clk;              // 100 ns period

endmodule

// ==== verilog/board_specific_top.sv ====
// Sound meter board top

`timescale 1ns/1ns

module board_specific_top
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic CLK,
    input  logic rst_n,

    input  logic MIC_SD,
    output logic MIC_SCK,
    output logic MIC_WS,
    output logic MIC_LR,

    output logic TM_CLK,
    output logic TM_STB,
    output logic TM_DIO_OUT,
    output logic TM_DIO_OE,
    input  logic TM_DIO_IN
);

    mic_sample_t           mic_sample;
    display_t              display;
    tm_panel_t             panel;
    logic [W_TM_KEY - 1:0] tm_keys;

    //--------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk    ( CLK        ),
        .rst_n  ( rst_n      ),
        .sd     ( MIC_SD     ),
        .sck    ( MIC_SCK    ),
        .ws     ( MIC_WS     ),
        .lr     ( MIC_LR     ),
        .sample ( mic_sample )
    );

    sound_level_meter i_meter
    (
        .clk     ( CLK        ),
        .rst_n   ( rst_n      ),
        .sample  ( mic_sample ),
        .keys    ( tm_keys    ),
        .display ( display    )
    );

    seven_seg_formatter i_formatter
    (
        .display ( display ),
        .panel   ( panel   )
    );

    //--------------------------------------------------

    tm1638_board_controller i_tm1638
    (
        .clk         ( CLK        ),
        .rst_n       ( rst_n      ),
        .panel       ( panel      ),
        .keys        ( tm_keys    ),
        .sio_clk     ( TM_CLK     ),
        .sio_stb     ( TM_STB     ),
        .sio_dio_out ( TM_DIO_OUT ),
        .sio_dio_oe  ( TM_DIO_OE  ),
        .sio_dio_in  ( TM_DIO_IN  )
    );

endmodule

// ==== verilog/tm1638_board_controller.sv ====
// TM1638 panel controller

`timescale 1ns/1ns

module tm1638_board_controller
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  tm_panel_t             panel,
    output logic [W_TM_KEY - 1:0] keys,
    output logic                  sio_clk,
    output logic                  sio_stb,
    output logic                  sio_dio_out,
    output logic                  sio_dio_oe,
    input  logic                  sio_dio_in
);

    typedef enum logic [2:0] {
        IDLE,
        CMD_BYTE,
        DATA_BYTES,
        READ_BYTES,
        STB_GAP
    } state_e;

    typedef logic [$clog2(TM_DIV)         - 1:0] div_cnt_t;
    typedef logic [$clog2(2 * W_TM_DIGIT) - 1:0] byte_cnt_t;

    state_e                    state;
    div_cnt_t                  div_cnt;
    logic                      tick;        // One sio_clk half period elapsed
    logic                      phase;       // Low half 0, high half 1
    logic [2:0]                bit_cnt;
    byte_cnt_t                 byte_cnt;
    logic [1:0]                txn;         // Transaction within the sequence
    logic [7:0]                tx_sr;
    logic [4 * W_TM_KEY - 1:0] rx_sr;       // Two keys per read byte
    logic [4 * W_TM_KEY - 1:0] rx_next;
    logic                      read_rise;
    logic                      last_read;
    tm_panel_t                 snap;

    //--------------------------------------------------
    // Helpers

    function automatic tm_cmd_e txn_cmd(input logic [1:0] t);
        tm_cmd_e cmd;

        case (t)
            2'd0:    cmd = CMD_DATA_AUTO;
            2'd1:    cmd = CMD_ADDR_0;
            2'd2:    cmd = CMD_DISPLAY_ON;
            default: cmd = CMD_READ_KEYS;
        endcase
        return cmd;
    endfunction

    // Even address is a digit, odd address is its LED
    function automatic logic [7:0] data_byte(input tm_panel_t p, input byte_cnt_t idx);
        logic [7:0] b;

        if (idx[0])
            b = {7'd0, p.led[idx[$bits(idx) - 1:1]]};
        else
            b = p.seg[idx[$bits(idx) - 1:1]];
        return b;
    endfunction

    // Key 2b in bit 0 and key 2b+1 in bit 4 of read byte b
    function automatic logic [W_TM_KEY - 1:0] decode_keys(input logic [4 * W_TM_KEY - 1:0] rx);
        logic [W_TM_KEY - 1:0] k;

        for (int b = 0; b < W_TM_KEY / 2; b++)
        begin
            k[2 * b]     = rx[8 * b];
            k[2 * b + 1] = rx[8 * b + 4];
        end
        return k;
    endfunction

    //--------------------------------------------------
    // Serial sequencer

    assign tick        = (div_cnt == div_cnt_t'(TM_DIV - 1));
    assign sio_dio_out = tx_sr[0];                              // LSB first
    assign rx_next     = {sio_dio_in, rx_sr[$left(rx_sr):1]};
    assign read_rise   = tick && (state == READ_BYTES) && !phase;
    assign last_read   = read_rise && (bit_cnt == 3'd7)
                         && (byte_cnt == byte_cnt_t'(W_TM_KEY / 2 - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            div_cnt    <= '0;
            phase      <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            txn        <= '0;
            tx_sr      <= 8'hFF;
            sio_clk    <= 1'b1;
            sio_stb    <= 1'b1;
            sio_dio_oe <= 1'b1;
            keys       <= '0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (last_read)
                keys <= decode_keys(rx_next);

            if (tick)
            begin
                case (state)
                    IDLE, STB_GAP:
                    begin
                        if (state == STB_GAP && txn == 2'd3)
                            state <= IDLE;                      // Sequence done
                        else
                        begin
                            state   <= CMD_BYTE;
                            txn     <= (state == IDLE) ? 2'd0 : txn + 1'b1;
                            tx_sr   <= (state == IDLE) ? txn_cmd(2'd0) : txn_cmd(txn + 1'b1);
                            sio_stb <= 1'b0;
                            sio_clk <= 1'b0;
                            phase   <= 1'b0;
                            bit_cnt <= '0;
                        end
                    end

                    default:                                    // Byte shifting states
                    begin
                        if (!phase)
                        begin
                            sio_clk <= 1'b1;                    // Panel samples here
                            phase   <= 1'b1;
                        end
                        else if (bit_cnt != 3'd7)
                        begin
                            sio_clk <= 1'b0;
                            phase   <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_sr   <= {1'b1, tx_sr[7:1]};
                        end
                        else
                        begin
                            phase   <= 1'b0;
                            bit_cnt <= '0;

                            if (state == CMD_BYTE && txn_cmd(txn) == CMD_ADDR_0)
                            begin
                                state    <= DATA_BYTES;
                                byte_cnt <= '0;
                                tx_sr    <= data_byte(snap, '0);
                                sio_clk  <= 1'b0;
                            end
                            else if (state == CMD_BYTE && txn_cmd(txn) == CMD_READ_KEYS)
                            begin
                                state      <= READ_BYTES;
                                byte_cnt   <= '0;
                                tx_sr      <= 8'hFF;
                                sio_dio_oe <= 1'b0;             // Panel drives dio
                                sio_clk    <= 1'b0;
                            end
                            else if (state == DATA_BYTES
                                     && byte_cnt != byte_cnt_t'(2 * W_TM_DIGIT - 1))
                            begin
                                byte_cnt <= byte_cnt + 1'b1;
                                tx_sr    <= data_byte(snap, byte_cnt + 1'b1);
                                sio_clk  <= 1'b0;
                            end
                            else if (state == READ_BYTES
                                     && byte_cnt != byte_cnt_t'(W_TM_KEY / 2 - 1))
                            begin
                                byte_cnt <= byte_cnt + 1'b1;
                                sio_clk  <= 1'b0;
                            end
                            else
                            begin
                                state      <= STB_GAP;          // sio_clk stays high
                                sio_stb    <= 1'b1;
                                sio_dio_oe <= 1'b1;
                                tx_sr      <= 8'hFF;
                            end
                        end
                    end
                endcase
            end
        end
    end

    //--------------------------------------------------
    // Frame snapshot and key capture

    always_ff @(posedge clk)
    begin
        if (tick && state == IDLE)
            snap <= panel;                              // One consistent frame

        if (read_rise)
            rx_sr <= rx_next;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !sio_dio_oe |-> state == READ_BYTES);

    assert property (@(posedge clk) disable iff (!rst_n)
        sio_stb |-> sio_clk);

endmodule

// ==== verilog/seven_seg_formatter.sv ====
// Hex digit formatter

`timescale 1ns/1ns

module seven_seg_formatter
    import board_pkg::*;
(
    input  display_t  display,
    output tm_panel_t panel
);

    // Segments a to g in bits 0 to 6, decimal point h in bit 7
    function automatic logic [7:0] hex_abcdefgh(input logic [3:0] nibble);
        logic [7:0] seg;

        case (nibble)
            4'h0:    seg = 8'b0011_1111;
            4'h1:    seg = 8'b0000_0110;
            4'h2:    seg = 8'b0101_1011;
            4'h3:    seg = 8'b0100_1111;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b0110_1101;
            4'h6:    seg = 8'b0111_1101;
            4'h7:    seg = 8'b0000_0111;
            4'h8:    seg = 8'b0111_1111;
            4'h9:    seg = 8'b0110_1111;
            4'hA:    seg = 8'b0111_0111;
            4'hB:    seg = 8'b0111_1100;   // Lower case b
            4'hC:    seg = 8'b0011_1001;
            4'hD:    seg = 8'b0101_1110;   // Lower case d
            4'hE:    seg = 8'b0111_1001;
            default: seg = 8'b0111_0001;
        endcase
        return seg;
    endfunction

    // Panel byte has the point in bit 0 and segment a in bit 7
    function automatic logic [7:0] to_hgfedcba(input logic [7:0] abcdefgh);
        logic [7:0] rev;

        for (int i = 0; i < 8; i++)
            rev[i] = abcdefgh[7 - i];
        return rev;
    endfunction

    always_comb
    begin
        for (int d = 0; d < W_TM_DIGIT; d++)
            panel.seg[d] = '0;                  // Upper digits stay blank

        for (int d = 0; d < $bits(display.value) / 4; d++)
            panel.seg[d] = to_hgfedcba(hex_abcdefgh(display.value[4 * d +: 4]));

        panel.led = display.led_bar;
    end

endmodule

// ==== verilog/sound_level_meter.sv ====
// Sound level meter

`timescale 1ns/1ns

module sound_level_meter
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  mic_sample_t           sample,
    input  logic [W_TM_KEY - 1:0] keys,
    output display_t              display
);

    logic [W_TM_KEY - 1:0]        keys_q;
    logic                         clear_rise;
    logic                         mode_rise;
    logic [W_SAMPLE - 1:0]        magnitude;
    logic [W_SAMPLE - 1:0]        peak;
    logic signed [W_SAMPLE - 1:0] latest;
    display_mode_e                mode;

    //--------------------------------------------------
    // Key edges and sample magnitude

    assign clear_rise = keys[0] & ~keys_q[0];   // Key 0 clears the peak
    assign mode_rise  = keys[1] & ~keys_q[1];   // Key 1 flips the mode

    // Most negative sample maps to 2**23, still fits unsigned
    assign magnitude = sample.value[W_SAMPLE - 1] ? $unsigned(-sample.value)
                                                  : $unsigned(sample.value);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            keys_q <= '0;
            peak   <= '0;
            latest <= '0;
            mode   <= SHOW_SAMPLE;
        end
        else
        begin
            keys_q <= keys;

            if (clear_rise)
                peak <= '0;                             // Clear wins over a sample
            else if (sample.strobe && (magnitude > peak))
                peak <= magnitude;

            if (sample.strobe)
                latest <= sample.value;

            if (mode_rise)
                mode <= (mode == SHOW_SAMPLE) ? SHOW_PEAK : SHOW_SAMPLE;
        end
    end

    //--------------------------------------------------
    // Display value and LED bar

    always_comb
    begin
        display.value = (mode == SHOW_PEAK) ? peak : $unsigned(latest);

        // LED i needs a peak of 2**(16 + i)
        for (int i = 0; i < W_TM_LED; i++)
            display.led_bar[i] = peak >= (W_SAMPLE'(1) << (W_SAMPLE - W_TM_LED + i));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !clear_rise |=> peak >= $past(peak));

endmodule

// ==== verilog/inmp441_mic_i2s_receiver.sv ====
// INMP441 I2S receiver

`timescale 1ns/1ns

module inmp441_mic_i2s_receiver
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output logic        lr,
    output mic_sample_t sample
);

    typedef logic [$clog2(SCK_DIV)       - 1:0] div_cnt_t;
    typedef logic [$clog2(2 * SLOT_BITS) - 1:0] bit_cnt_t;

    div_cnt_t              div_cnt;
    bit_cnt_t              bit_cnt;     // sck period within the frame
    logic                  sck_edge;
    logic                  sck_rise;
    logic                  sck_fall;
    logic                  capture;
    logic                  strobe;
    logic [W_SAMPLE - 1:0] shift_sr;

    //--------------------------------------------------
    // Bit clock and word select

    assign sck_edge = (div_cnt == div_cnt_t'(SCK_DIV - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge &  sck;

    assign ws = bit_cnt[$left(bit_cnt)];    // Low in the left slot
    assign lr = 1'b0;                       // Mic answers in the left slot

    // MSB arrives one sck period after ws falls
    assign capture = sck_rise
                     && (bit_cnt >= bit_cnt_t'(1))
                     && (bit_cnt <= bit_cnt_t'(W_SAMPLE));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            strobe  <= 1'b0;
        end
        else
        begin
            div_cnt <= sck_edge ? '0 : div_cnt + 1'b1;

            if (sck_edge)
                sck <= ~sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;                      // ws follows on this edge

            strobe <= capture && (bit_cnt == bit_cnt_t'(W_SAMPLE)); // LSB just taken
        end
    end

    //--------------------------------------------------
    // Sample shift register

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_sr <= {shift_sr[W_SAMPLE - 2:0], sd};     // MSB first
    end

    assign sample.strobe = strobe;
    assign sample.value  = signed'(shift_sr);

    // New samples are a full frame apart, never back to back
    assert property (@(posedge clk) disable iff (!rst_n)
        sample.strobe |=> !sample.strobe);

endmodule

// ==== verilog/audio_pkg.sv ====
// Microphone and meter definitions

package audio_pkg;

    //--------------------------------------------------
    // I2S framing

    localparam int W_SAMPLE  = 24;  // INMP441 sample width
    localparam int SCK_DIV   = 4;   // clk cycles per half period of sck
    localparam int SLOT_BITS = 32;  // sck periods per channel slot

    //--------------------------------------------------
    // Sample stream toward the meter

    typedef struct packed {
        logic                         strobe;   // One clk cycle per new sample
        logic signed [W_SAMPLE - 1:0] value;
    } mic_sample_t;

    //--------------------------------------------------
    // What the digits show

    typedef enum logic {
        SHOW_SAMPLE = 1'b0,
        SHOW_PEAK   = 1'b1
    } display_mode_e;

endpackage

// ==== verilog/board_pkg.sv ====
// TM1638 panel definitions

package board_pkg;

    //--------------------------------------------------
    // Panel geometry and serial timing

    localparam int W_TM_DIGIT = 8;  // 7-segment digits
    localparam int W_TM_LED   = 8;  // Discrete LEDs
    localparam int W_TM_KEY   = 8;  // Scanned keys

    localparam int TM_DIV     = 2;  // clk cycles per half period of sio_clk

    //--------------------------------------------------
    // Command opcodes

    typedef enum logic [7:0] {
        CMD_DATA_AUTO  = 8'h40,     // Write data, address auto increment
        CMD_ADDR_0     = 8'hC0,     // Start at address 0
        CMD_DISPLAY_ON = 8'h8F,     // Display on, full brightness
        CMD_READ_KEYS  = 8'h42      // Key scan read
    } tm_cmd_e;

    //--------------------------------------------------
    // Panel contents and meter display

    typedef struct packed {
        logic [W_TM_DIGIT - 1:0][7:0] seg;  // One hgfedcba byte per digit
        logic [W_TM_LED   - 1:0]      led;  // Bit i lights LED i
    } tm_panel_t;

    typedef struct packed {
        logic [23:0]           value;       // Six hex digits
        logic [W_TM_LED - 1:0] led_bar;
    } display_t;

endpackage
